/* hw/mb128_pkg.sv */
`default_nettype none

// joypad side of the MB128 emulation
package mb128_pkg;

  ////////////////////////////////////////
  // widths that carry a meaning

  typedef logic [16:0] mem_addr_t;   // byte address, 128 KiB store
  typedef logic [16:0] byte_cnt_t;   // transfer length in bytes
  typedef logic [7:0]  data_byte_t;  // one data byte, also used on the spi side

  // protocol FSM, one step per filtered joypad clock
  typedef enum logic [3:0] {
    idle,         // hunting for the sync byte
    sync_ack,     // one clock after 0xA8
    ident,        // host bit echoed on the ident line
    req,          // request bit, 0 = write
    addr,         // 10 address bits in 128 byte units
    len_bits,     // 3 bit-count bits, shifted past
    len_bytes,    // 17 byte-count bits
    read,
    read_trail,
    write,
    write_trail
  } state_t;

  ////////////////////////////////////////
  // framing constants

  localparam data_byte_t SYNC_BYTE     = 8'hA8;
  localparam int         SYNC_MIN_BITS = 8;   // training bits before a match counts
  localparam int ADDR_BITS        = 10;
  localparam int LEN_BITS_BITS    = 3;
  localparam int LEN_BYTES_BITS   = 17;
  localparam int READ_TRAIL_CLKS  = 3;
  localparam int WRITE_TRAIL_CLKS = 5;

  localparam logic CMD_WRITE_BIT = 1'b0;  // request bit value for a write

  // equal samples needed before a clock level is taken
  localparam int FILTER_LEN = 30;

endpackage

`default_nettype wire

/* hw/spi_mem_pkg.sv */
`default_nettype none

// serial RAM side, 03/02/06 command set
package spi_mem_pkg;

  localparam logic [7:0] SPI_READ_CMD  = 8'h03;
  localparam logic [7:0] SPI_WRITE_CMD = 8'h02;
  localparam logic [7:0] SPI_WREN_CMD  = 8'h06;  // write enable latch

  localparam int SPI_ADDR_W = 24;  // address bytes the part expects

  // frame lengths in spi bits
  localparam int CMD_FRAME_LEN  = 32;  // command byte plus address
  localparam int WREN_FRAME_LEN = 8;   // command byte alone

  // quarter period of the spi clock
  //  0 drive mosi, 1 sclk high, 2 sample miso, 3 sclk low
  typedef logic [1:0] spi_phase_t;

endpackage

`default_nettype wire

/* hw/mem_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

// request path from the protocol engine to the spi master
interface mem_req_if;

  logic rd_req;    // read one byte at addr
  logic wr_req;    // write wdata at addr
  logic wren_req;  // send write enable only

  mb128_pkg::mem_addr_t  addr;
  mb128_pkg::data_byte_t wdata;

  // answer from the memory side
  mb128_pkg::data_byte_t rdata;
  logic                  rd_done;  // rdata valid on this cycle

  modport proto (
    output rd_req, wr_req, wren_req, addr, wdata,
    input  rdata, rd_done
  );

  modport spi (
    input  rd_req, wr_req, wren_req, addr, wdata,
    output rdata, rd_done
  );

endinterface

`default_nettype wire

/* hw/joy_clk_filter.sv */
`timescale 1ns/100ps
`default_nettype none

// cleans the joypad clock, long cable and slow edges
module joy_clk_filter (
  input  wire logic clk_sys,
  input  wire logic reset_n,
  input  wire logic i_joy_clk,  // raw clear line
  output logic      o_level,    // filtered level
  output logic      o_rise      // one cycle per filtered rising edge
);

  logic [mb128_pkg::FILTER_LEN-1:0] hist;  // sample history, newest in bit 0
  logic                             level_d;

  always_ff @(posedge clk_sys)
  begin
    if (!reset_n)
    begin
      hist    <= '0;
      o_level <= 1'b0;
      level_d <= 1'b0;
      o_rise  <= 1'b0;
    end
    else
    begin
      hist <= {hist[mb128_pkg::FILTER_LEN-2:0], i_joy_clk};
      if (&hist)
        o_level <= 1'b1;  // all high
      else if (~|hist)
        o_level <= 1'b0;  // all low
      // anything mixed keeps the old level
      level_d <= o_level;
      o_rise  <= o_level & ~level_d;  // lands one cycle after the level
    end
  end

endmodule

`default_nettype wire

/* hw/mb128_protocol.sv */
`timescale 1ns/100ps
`default_nettype none

// joypad side protocol engine
// everything moves on the filtered rising edge of the clear line
module mb128_protocol (
  input  wire logic clk_sys,
  input  wire logic reset_n,
  input  wire logic i_joy_clk,   // raw line, only for the active release
  input  wire logic i_rise,      // filtered rising edge
  input  wire logic i_joy_data,  // select line from the console
  mem_req_if.proto  mem,
  output logic      o_active,
  output logic      o_data,
  output logic      o_ident,
  output logic      o_read_led,
  output logic      o_write_led
);

  mb128_pkg::state_t     state;
  logic [4:0]            bit_cnt;      // bit index inside the current field
  mb128_pkg::data_byte_t shift_reg;    // sync hunt and write byte assembly
  logic                  req_bit;      // latched request bit
  logic                  stop_active;  // drop active on the next low clock
  mb128_pkg::mem_addr_t  addr_sh;      // address as it arrives
  mb128_pkg::mem_addr_t  addr_cur;     // running transfer address
  mb128_pkg::byte_cnt_t  bytes_left;
  mb128_pkg::data_byte_t rd_byte;      // prefetched byte, goes out lsb first

  mb128_pkg::data_byte_t shift_next;
  mb128_pkg::mem_addr_t  addr_next;
  mb128_pkg::byte_cnt_t  bytes_next;
  logic                  is_write;
  logic [4:0]            trail_end;

  // all fields arrive lsb first
  assign shift_next = {i_joy_data, shift_reg[7:1]};
  assign addr_next  = {i_joy_data, addr_sh[16:1]};   // 10 shifts end in bits 16..7
  assign bytes_next = {i_joy_data, bytes_left[16:1]};
  assign is_write   = (req_bit == mb128_pkg::CMD_WRITE_BIT);

  assign trail_end = (state == mb128_pkg::read_trail) ? 5'(mb128_pkg::READ_TRAIL_CLKS - 1)
                                                     : 5'(mb128_pkg::WRITE_TRAIL_CLKS - 1);

  assign mem.addr = addr_cur;

  always_ff @(posedge clk_sys)
  begin
    if (!reset_n)
    begin
      state        <= mb128_pkg::idle;
      bit_cnt      <= '0;
      shift_reg    <= '0;
      req_bit      <= 1'b0;
      stop_active  <= 1'b0;
      o_active     <= 1'b0;
      o_data       <= 1'b0;
      o_ident      <= 1'b0;
      o_read_led   <= 1'b0;
      o_write_led  <= 1'b0;
      mem.rd_req   <= 1'b0;
      mem.wr_req   <= 1'b0;
      mem.wren_req <= 1'b0;
    end
    else
    begin
      mem.rd_req   <= 1'b0;  // strobes, one cycle
      mem.wr_req   <= 1'b0;
      mem.wren_req <= 1'b0;

      if (mem.wr_req)
        addr_cur <= addr_cur + 1'b1;  // step once the spi side has taken the byte

      // stay active through the high half, let go when the line drops
      if (!i_joy_clk && stop_active)
      begin
        o_active    <= 1'b0;
        stop_active <= 1'b0;
      end

      if (mem.rd_done)
        rd_byte <= mem.rdata;

      if (i_rise)
      begin
        case (state)

          ////////////////////////////////////////
          // sync and ident

          mb128_pkg::idle:
          begin
            shift_reg <= shift_next;
            o_data    <= 1'b0;
            o_ident   <= 1'b0;
            if (bit_cnt < 5'(mb128_pkg::SYNC_MIN_BITS - 1))
              bit_cnt <= bit_cnt + 5'd1;  // saturating training count
            if ((shift_next == mb128_pkg::SYNC_BYTE) &&
                (bit_cnt >= 5'(mb128_pkg::SYNC_MIN_BITS - 1)))
            begin
              o_active <= 1'b1;  // take over the port
              bit_cnt  <= '0;
              state    <= mb128_pkg::sync_ack;
            end
          end

          mb128_pkg::sync_ack:
            state <= mb128_pkg::ident;

          mb128_pkg::ident:
          begin
            o_ident <= i_joy_data;  // echo the host bit
            state   <= mb128_pkg::req;
          end

          ////////////////////////////////////////
          // request header

          mb128_pkg::req:
          begin
            o_ident <= 1'b0;
            req_bit <= i_joy_data;
            if (i_joy_data == mb128_pkg::CMD_WRITE_BIT)
              o_write_led <= 1'b1;
            else
              o_read_led <= 1'b1;
            addr_sh <= '0;
            bit_cnt <= '0;
            state   <= mb128_pkg::addr;
          end

          mb128_pkg::addr:
          begin
            addr_sh <= addr_next;
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(mb128_pkg::ADDR_BITS - 1))
            begin
              addr_cur <= addr_next;
              if (is_write)
                mem.wren_req <= 1'b1;  // unlock the RAM early
              else
                mem.rd_req <= 1'b1;    // fetch the first byte ahead of use
              bit_cnt <= '0;
              state   <= mb128_pkg::len_bits;
            end
          end

          // sub-byte count, only keeps the frame aligned
          mb128_pkg::len_bits:
          begin
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(mb128_pkg::LEN_BITS_BITS - 1))
            begin
              bit_cnt <= '0;
              state   <= mb128_pkg::len_bytes;
            end
          end

          mb128_pkg::len_bytes:
          begin
            bytes_left <= bytes_next;
            bit_cnt    <= bit_cnt + 5'd1;
            if (bit_cnt == 5'(mb128_pkg::LEN_BYTES_BITS - 1))
            begin
              bit_cnt <= '0;
              o_data  <= req_bit;  // header ack, high for a read
              if (bytes_next == '0)
                state <= is_write ? mb128_pkg::write_trail : mb128_pkg::read_trail;
              else
                state <= is_write ? mb128_pkg::write : mb128_pkg::read;
            end
          end

          ////////////////////////////////////////
          // payload

          mb128_pkg::read:
          begin
            o_data  <= rd_byte[0];
            rd_byte <= {1'b0, rd_byte[7:1]};
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == 5'd7)
            begin
              bit_cnt <= '0;
              if (bytes_left == 17'd1)
                state <= mb128_pkg::read_trail;
              else
              begin
                bytes_left <= bytes_left - 1'b1;
                addr_cur   <= addr_cur + 1'b1;
                mem.rd_req <= 1'b1;  // next byte, seen with the new address
              end
            end
          end

          mb128_pkg::write:
          begin
            o_data    <= 1'b0;
            shift_reg <= shift_next;
            bit_cnt   <= bit_cnt + 5'd1;
            if (bit_cnt == 5'd7)
            begin
              bit_cnt    <= '0;
              mem.wdata  <= shift_next;
              mem.wr_req <= 1'b1;
              if (bytes_left == 17'd1)
                state <= mb128_pkg::write_trail;
              else
                bytes_left <= bytes_left - 1'b1;
            end
          end

          // both trails only differ in length
          mb128_pkg::read_trail, mb128_pkg::write_trail:
          begin
            o_data  <= 1'b0;
            bit_cnt <= bit_cnt + 5'd1;
            if (bit_cnt == trail_end)
            begin
              state       <= mb128_pkg::idle;
              bit_cnt     <= '0;
              shift_reg   <= '0;
              stop_active <= 1'b1;
              o_read_led  <= 1'b0;
              o_write_led <= 1'b0;
            end
          end

          default:
          begin
            state       <= mb128_pkg::idle;
            bit_cnt     <= '0;
            stop_active <= 1'b1;
            o_read_led  <= 1'b0;
            o_write_led <= 1'b0;
          end

        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* hw/spi_mem_master.sv */
`timescale 1ns/100ps
`default_nettype none

// spi master for the serial RAM at four clk_sys per spi bit
module spi_mem_master (
  input  wire logic clk_sys,
  input  wire logic reset_n,
  mem_req_if.spi    mem,
  output logic      o_spi_cs_n,
  output logic      o_spi_clk,
  output logic      o_spi_mosi,
  output logic      o_spi_hold_n,
  input  wire logic i_spi_miso
);

  spi_mem_pkg::spi_phase_t                   phase;   // free running
  logic [spi_mem_pkg::CMD_FRAME_LEN-1:0]     cmd_sh;  // command and address go out msb first
  logic [5:0]                                cmd_cnt;
  mb128_pkg::data_byte_t                     wr_sh;
  mb128_pkg::data_byte_t                     rd_sh;
  logic [3:0]                                data_cnt;
  logic                                      go;         // loaded and waiting for phase 3
  logic                                      busy;       // frame on the wire
  logic                                      is_read;
  logic                                      is_write;
  logic                                      wren_pend;  // write enable owed after a write
  logic                                      start;

  // requests only count while nothing is loaded or running
  assign start = !go && !busy &&
                 (mem.rd_req || mem.wr_req || mem.wren_req || wren_pend);

  assign mem.rdata = rd_sh;

  always_ff @(posedge clk_sys)
  begin
    if (!reset_n)
    begin
      phase        <= '0;
      cmd_cnt      <= '0;
      data_cnt     <= '0;
      go           <= 1'b0;
      busy         <= 1'b0;
      is_read      <= 1'b0;
      is_write     <= 1'b0;
      wren_pend    <= 1'b0;
      mem.rd_done  <= 1'b0;
      o_spi_cs_n   <= 1'b1;
      o_spi_clk    <= 1'b0;
      o_spi_mosi   <= 1'b0;
      o_spi_hold_n <= 1'b0;
    end
    else
    begin
      phase       <= phase + 2'd1;
      mem.rd_done <= 1'b0;

      ////////////////////////////////////////
      // frame load

      if (start)
      begin
        go        <= 1'b1;
        wren_pend <= 1'b0;
        is_read   <= mem.rd_req;
        is_write  <= mem.wr_req;
        wr_sh     <= mem.wr_req ? mem.wdata : '0;
        if (mem.rd_req || mem.wr_req)
        begin
          cmd_sh   <= {(mem.rd_req ? spi_mem_pkg::SPI_READ_CMD : spi_mem_pkg::SPI_WRITE_CMD),
                       spi_mem_pkg::SPI_ADDR_W'(mem.addr)};
          cmd_cnt  <= 6'(spi_mem_pkg::CMD_FRAME_LEN);
          data_cnt <= 4'd8;
        end
        else
        begin
          // write enable is the command byte alone
          cmd_sh   <= {spi_mem_pkg::SPI_WREN_CMD, {spi_mem_pkg::SPI_ADDR_W{1'b0}}};
          cmd_cnt  <= 6'(spi_mem_pkg::WREN_FRAME_LEN);
          data_cnt <= '0;
        end
      end

      ////////////////////////////////////////
      // bit engine

      case (phase)
        2'd0:
        begin
          if (busy)
          begin
            o_spi_cs_n   <= 1'b0;
            o_spi_hold_n <= 1'b1;
            if (cmd_cnt != '0)
            begin
              o_spi_mosi <= cmd_sh[spi_mem_pkg::CMD_FRAME_LEN-1];
              cmd_sh     <= {cmd_sh[spi_mem_pkg::CMD_FRAME_LEN-2:0], 1'b0};
            end
            if (cmd_cnt == '0 && data_cnt != '0)
            begin
              o_spi_mosi <= wr_sh[7];  // data byte goes out msb first
              wr_sh      <= {wr_sh[6:0], 1'b0};
            end
          end
          else
            o_spi_cs_n <= 1'b1;  // deselect between frames
        end

        2'd1:
          if (busy)
            o_spi_clk <= 1'b1;

        2'd2:
        begin
          if (busy && cmd_cnt != '0)
            cmd_cnt <= cmd_cnt - 6'd1;
          else if (busy && data_cnt != '0)
          begin
            if (is_read)
              rd_sh <= {rd_sh[6:0], i_spi_miso};  // sample while sclk is high
            data_cnt <= data_cnt - 4'd1;
          end
        end

        default:
        begin
          o_spi_clk <= 1'b0;
          if (go)
          begin
            busy <= 1'b1;
            go   <= 1'b0;
          end
          if (busy && cmd_cnt == '0 && data_cnt == '0)
          begin
            busy        <= 1'b0;
            mem.rd_done <= is_read;
            wren_pend   <= is_write;  // re-arm the RAM after every write
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hw/mb128_top.sv */
`timescale 1ns/100ps
`default_nettype none

// MB128 unit, joypad port on one side, spi RAM on the other
module mb128_top (
  input  wire logic clk_sys,
  input  wire logic reset_n,

  // joypad port
  input  wire logic i_joy_clk,     // clear line
  input  wire logic i_joy_data,    // select line
  output wire logic o_active,
  output wire logic o_data,
  output wire logic o_ident,
  output wire logic o_read_led,
  output wire logic o_write_led,

  // serial RAM
  output wire logic o_spi_cs_n,
  output wire logic o_spi_clk,
  output wire logic o_spi_mosi,
  output wire logic o_spi_hold_n,
  input  wire logic i_spi_miso
);

  wire logic joy_rise;  // filtered clock edge

  mem_req_if mem ();

  joy_clk_filter u_filter (
    .clk_sys   (clk_sys),
    .reset_n   (reset_n),
    .i_joy_clk (i_joy_clk),
    .o_level   (),            // edge strobe carries all the timing
    .o_rise    (joy_rise)
  );

  mb128_protocol u_proto (
    .clk_sys     (clk_sys),
    .reset_n     (reset_n),
    .i_joy_clk   (i_joy_clk),
    .i_rise      (joy_rise),
    .i_joy_data  (i_joy_data),
    .mem         (mem.proto),
    .o_active    (o_active),
    .o_data      (o_data),
    .o_ident     (o_ident),
    .o_read_led  (o_read_led),
    .o_write_led (o_write_led)
  );

  spi_mem_master u_spi (
    .clk_sys      (clk_sys),
    .reset_n      (reset_n),
    .mem          (mem.spi),
    .o_spi_cs_n   (o_spi_cs_n),
    .o_spi_clk    (o_spi_clk),
    .o_spi_mosi   (o_spi_mosi),
    .o_spi_hold_n (o_spi_hold_n),
    .i_spi_miso   (i_spi_miso)
  );

endmodule

`default_nettype wire

/* bench/spi_ram_model.sv */
`timescale 1ns/100ps
`default_nettype none

// behavioral 128 KiB spi serial RAM, mode 0, single byte READ and WRITE
module spi_ram_model #(
  parameter logic [31:0] SEED = 32'h0  // fill seed
) (
  input  wire logic   i_cs_n,
  input  wire logic   i_sclk,
  input  wire logic   i_mosi,
  input  wire logic   i_hold_n,
  output logic        o_miso,
  output logic [31:0] o_wel_errs  // writes seen with the enable latch clear
);

  logic [7:0]  mem [0:131071];
  integer      fill_seed;
  logic [31:0] rnd;
  logic [16:0] fill_addr;
  int          bit_cnt;  // sclk rising edges in this frame
  logic [31:0] rx_sh;    // mosi history, newest in bit 0
  logic [7:0]  cmd;
  logic [16:0] addr;     // low bits of the 24 bit address field
  logic [7:0]  wdata;
  logic [7:0]  tx_sh;    // read byte, msb goes out first
  logic        wel;      // write enable latch

  initial
  begin
    fill_seed  = SEED;
    wel        = 1'b0;
    bit_cnt    = 0;
    rx_sh      = '0;
    cmd        = '0;
    o_miso     = 1'b0;
    o_wel_errs = '0;
    // random fill mixed with the whole address
    for (int a = 0; a < 131072; a++)
    begin
      rnd       = $random(fill_seed);
      fill_addr = a[16:0];
      mem[a]    = rnd[7:0] ^ fill_addr[7:0] ^ fill_addr[15:8] ^ {7'b0, fill_addr[16]};
    end
  end

  always @(negedge i_cs_n)
  begin
    bit_cnt = 0;  // new frame
    rx_sh   = '0;
    cmd     = '0;
  end

  always @(posedge i_sclk)
  begin
    if (!i_cs_n && i_hold_n)
    begin
      rx_sh   = {rx_sh[30:0], i_mosi};
      bit_cnt = bit_cnt + 1;
      if (bit_cnt == 8)
        cmd = rx_sh[7:0];
      if (bit_cnt == 32)
        addr = rx_sh[16:0];  // upper address byte ignored, 128 KiB part
      if (bit_cnt == 40)
        wdata = rx_sh[7:0];
    end
  end

  // miso moves on the falling edge, master samples while sclk is high
  always @(negedge i_sclk)
  begin
    if (!i_cs_n && i_hold_n && cmd == spi_mem_pkg::SPI_READ_CMD)
    begin
      if (bit_cnt == 32)
        tx_sh = mem[addr];
      if (bit_cnt >= 32 && bit_cnt < 40)
      begin
        o_miso = tx_sh[7];
        tx_sh  = {tx_sh[6:0], 1'b0};
      end
    end
  end

  // commands take effect when chip select goes high
  always @(posedge i_cs_n)
  begin
    if (cmd == spi_mem_pkg::SPI_WREN_CMD && bit_cnt == 8)
      wel = 1'b1;
    else if (cmd == spi_mem_pkg::SPI_WRITE_CMD && bit_cnt == 40)
    begin
      if (wel)
        mem[addr] = wdata;
      else
        o_wel_errs = o_wel_errs + 1;
      wel = 1'b0;  // latch drops after every write
    end
  end

endmodule

`default_nettype wire

/* bench/tb_mb128.sv */
`timescale 1ns/100ps
`default_nettype none

// joypad host against the MB128 unit and a serial RAM model
module tb_mb128;

  localparam int HALF_CLKS  = 200;  // joypad half period in clk_sys cycles
  localparam int NOISE_BITS = 24;
  localparam int NUM_XFERS  = 11;   // 3 writes, 3 read backs, 3 reads, 2 empty
  // sync, ack, ident, req and the three header fields
  localparam int HDR_BITS   = 11 + mb128_pkg::ADDR_BITS + mb128_pkg::LEN_BITS_BITS +
                              mb128_pkg::LEN_BYTES_BITS;
  localparam int XFER_BITS  = HDR_BITS + 4 * 8 + mb128_pkg::WRITE_TRAIL_CLKS;  // worst case
  localparam int TEST_BITS  = NOISE_BITS + 12 + NUM_XFERS * XFER_BITS;
  localparam int WD_CYCLES  = TEST_BITS * 2 * HALF_CLKS * 3 / 2;  // 50 percent margin

  logic        clk_sys;
  logic        reset_n;
  logic        i_joy_clk;
  logic        i_joy_data;
  wire         o_active;
  wire         o_data;
  wire         o_ident;
  wire         o_read_led;
  wire         o_write_led;
  wire         spi_cs_n;
  wire         spi_clk;
  wire         spi_mosi;
  wire         spi_hold_n;
  wire         spi_miso;
  wire [31:0]  wel_errs;

  integer      seed;
  int          err_cnt;
  int          chk_cnt;
  logic [7:0]  xfer_buf [0:3];  // bytes to write, or bytes expected back
  logic        smp_data;        // outputs taken just before a joypad rising edge
  logic        smp_ident;
  logic        smp_active;
  logic        smp_rled;
  logic        smp_wled;

  mb128_top UUT (
    .clk_sys      (clk_sys),
    .reset_n      (reset_n),
    .i_joy_clk    (i_joy_clk),
    .i_joy_data   (i_joy_data),
    .o_active     (o_active),
    .o_data       (o_data),
    .o_ident      (o_ident),
    .o_read_led   (o_read_led),
    .o_write_led  (o_write_led),
    .o_spi_cs_n   (spi_cs_n),
    .o_spi_clk    (spi_clk),
    .o_spi_mosi   (spi_mosi),
    .o_spi_hold_n (spi_hold_n),
    .i_spi_miso   (spi_miso)
  );

  spi_ram_model #(.SEED(32'h5b36163a)) u_ram (
    .i_cs_n     (spi_cs_n),
    .i_sclk     (spi_clk),
    .i_mosi     (spi_mosi),
    .i_hold_n   (spi_hold_n),
    .o_miso     (spi_miso),
    .o_wel_errs (wel_errs)
  );

  initial
  begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  ////////////////////////////////////////
  // checks

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    assert (got === exp)
    else
    begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
      err_cnt++;
    end
  endtask

  // port owned, matching light on
  task automatic check_xfer_flags(input logic wr);
    check_val("o_active", smp_active, 1'b1);
    check_val("o_read_led", smp_rled, !wr);
    check_val("o_write_led", smp_wled, wr);
  endtask

  ////////////////////////////////////////
  // joypad host

  // low half with data set up, sample, then high half
  task automatic clock_bit(input logic d);
    @(posedge clk_sys);
    i_joy_clk  <= 1'b0;
    i_joy_data <= d;
    repeat (HALF_CLKS - 1) @(posedge clk_sys);
    @(negedge clk_sys);
    smp_data   = o_data;
    smp_ident  = o_ident;
    smp_active = o_active;
    smp_rled   = o_read_led;
    smp_wled   = o_write_led;
    @(posedge clk_sys);
    i_joy_clk <= 1'b1;
    repeat (HALF_CLKS - 1) @(posedge clk_sys);
  endtask

  // high for fewer cycles than the filter needs
  task automatic short_pulse(input logic d, input int len);
    @(posedge clk_sys);
    i_joy_clk  <= 1'b0;
    i_joy_data <= d;
    repeat (HALF_CLKS) @(posedge clk_sys);
    i_joy_clk <= 1'b1;
    repeat (len) @(posedge clk_sys);
    i_joy_clk <= 1'b0;
  endtask

  task automatic send_noise();
    logic [7:0] win;   // last 8 bits, lsb first like the sync hunt
    logic [7:0] sync_v;
    logic [31:0] rnd;
    logic b;
    sync_v = mb128_pkg::SYNC_BYTE;
    win    = '0;
    for (int k = 0; k < NOISE_BITS; k++)
    begin
      rnd = $random(seed);
      b   = rnd[0];
      if ({b, win[7:1]} == sync_v)
        b = ~b;  // never complete the sync byte
      win = {b, win[7:1]};
      clock_bit(b);
      check_val("o_active", smp_active, 1'b0);
    end
    // 7 sync bits, the last one only on glitches
    for (int k = 0; k < 7; k++)
    begin
      clock_bit(sync_v[k]);
      check_val("o_active", smp_active, 1'b0);
    end
    short_pulse(sync_v[7], 29);
    short_pulse(sync_v[7], 12);
    clock_bit(~sync_v[7]);
    check_val("o_active", smp_active, 1'b0);
    clock_bit(1'b0);
    check_val("o_active", smp_active, 1'b0);
  endtask

  task automatic run_transfer(input logic wr, input logic [9:0] blk, input int n);
    logic [7:0]  sync_v;
    logic [16:0] base;
    logic [16:0] cnt;
    logic [31:0] rnd;
    logic        id_bit;
    int          trail;
    sync_v = mb128_pkg::SYNC_BYTE;
    base   = {blk, 7'd0};  // 128 byte units
    cnt    = 17'(n);
    rnd    = $random(seed);
    id_bit = rnd[0];
    trail  = wr ? mb128_pkg::WRITE_TRAIL_CLKS : mb128_pkg::READ_TRAIL_CLKS;

    for (int k = 0; k < 8; k++)
    begin
      clock_bit(sync_v[k]);
      check_val("o_active", smp_active, 1'b0);
    end
    clock_bit(1'b0);  // ack clock
    check_val("o_active", smp_active, 1'b1);
    clock_bit(id_bit);
    clock_bit(wr ? mb128_pkg::CMD_WRITE_BIT : ~mb128_pkg::CMD_WRITE_BIT);
    check_val("o_ident", smp_ident, id_bit);  // echoed on the ident clock

    for (int k = 0; k < mb128_pkg::ADDR_BITS; k++)
    begin
      clock_bit(blk[k]);
      check_xfer_flags(wr);
    end
    for (int k = 0; k < mb128_pkg::LEN_BITS_BITS; k++)
    begin
      rnd = $random(seed);
      clock_bit(rnd[0]);  // sub-byte count, don't care
    end
    for (int k = 0; k < mb128_pkg::LEN_BYTES_BITS; k++)
      clock_bit(cnt[k]);

    ////////////////////////////////////////
    // payload, each sample shows the previous clock's bit
    for (int k = 0; k < 8 * n; k++)
    begin
      clock_bit(wr ? xfer_buf[k / 8][k % 8] : 1'b0);
      check_xfer_flags(wr);
      if (k > 0 && !wr)
        check_val("o_data", smp_data, xfer_buf[(k - 1) / 8][(k - 1) % 8]);
    end
    for (int k = 0; k < trail; k++)
    begin
      clock_bit(1'b0);
      check_xfer_flags(wr);
      if (k > 0)
        check_val("o_data", smp_data, 1'b0);
      else if (!wr && n > 0)
        check_val("o_data", smp_data, xfer_buf[n - 1][7]);
    end

    // last trail clock is still high
    @(negedge clk_sys);
    check_val("o_active", o_active, 1'b1);
    check_val("o_data", o_data, 1'b0);
    check_val("o_read_led", o_read_led, 1'b0);
    check_val("o_write_led", o_write_led, 1'b0);
    @(posedge clk_sys);
    i_joy_clk <= 1'b0;
    @(posedge clk_sys);
    @(negedge clk_sys);
    check_val("o_active", o_active, 1'b0);  // released on the first low cycle

    if (wr)
      for (int i = 0; i < n; i++)
        check_val("u_ram.mem", u_ram.mem[base + 17'(i)], xfer_buf[i]);
  endtask

  ////////////////////////////////////////
  // test sequence

  initial
  begin
    logic [31:0] rnd;
    logic [9:0]  blk;
    int          n;
    seed       = 32'h5b36163a;
    err_cnt    = 0;
    chk_cnt    = 0;
    reset_n    = 1'b0;
    i_joy_clk  = 1'b0;
    i_joy_data = 1'b0;
    repeat (8) @(posedge clk_sys);
    reset_n <= 1'b1;
    @(negedge clk_sys);
    check_val("o_active", o_active, 1'b0);
    check_val("o_data", o_data, 1'b0);
    check_val("o_ident", o_ident, 1'b0);
    check_val("o_read_led", o_read_led, 1'b0);
    check_val("o_write_led", o_write_led, 1'b0);
    check_val("o_spi_cs_n", spi_cs_n, 1'b1);
    check_val("o_spi_hold_n", spi_hold_n, 1'b0);
    check_val("o_spi_clk", spi_clk, 1'b0);

    send_noise();

    // write random bytes, then read them back through the unit
    for (int t = 0; t < 3; t++)
    begin
      rnd = $random(seed);
      blk = rnd[9:0];
      n   = 1 + rnd[11:10];
      for (int i = 0; i < 4; i++)
      begin
        rnd         = $random(seed);
        xfer_buf[i] = rnd[7:0];
      end
      run_transfer(1'b1, blk, n);
      run_transfer(1'b0, blk, n);
    end

    // reads of the preloaded contents
    for (int t = 0; t < 3; t++)
    begin
      rnd = $random(seed);
      blk = rnd[9:0];
      n   = 1 + rnd[11:10];
      for (int i = 0; i < n; i++)
        xfer_buf[i] = u_ram.mem[{blk, 7'd0} + 17'(i)];
      run_transfer(1'b0, blk, n);
    end

    // empty requests go straight to the trail
    rnd = $random(seed);
    run_transfer(1'b0, rnd[9:0], 0);
    run_transfer(1'b1, rnd[19:10], 0);

    chk_cnt++;
    assert (wel_errs == 0)
    else
    begin
      $display("serial RAM got %0d writes without a write enable", wel_errs);
      err_cnt++;
    end

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (WD_CYCLES) @(posedge clk_sys);
    $display("watchdog expired after %0d cycles, the tests did not finish", WD_CYCLES);
    $display("checks %0d, errors %0d", chk_cnt, err_cnt + 1);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
hw/mb128_pkg.sv
hw/spi_mem_pkg.sv
hw/mem_req_if.sv
hw/joy_clk_filter.sv
hw/mb128_protocol.sv
hw/spi_mem_master.sv
hw/mb128_top.sv
bench/spi_ram_model.sv
bench/tb_mb128.sv
